// File: logic/mmu_pkg.sv
package mmu_pkg;

	// --------------------------------------------------------------------
	// widths
	// --------------------------------------------------------------------
	localparam int XLEN          = 32;
	localparam int PAGE_OFFSET_W = 12;
	localparam int VPN_W         = 10;
	localparam int PPN_W         = 20;

	// response codes, same encoding as the AXI resp field
	localparam logic [1:0] RESP_OKAY       = 2'd0;
	localparam logic [1:0] RESP_PAGE_FAULT = 2'd2;

	// --------------------------------------------------------------------
	// bus payloads
	// --------------------------------------------------------------------
	typedef struct packed {
		logic [XLEN-1:0]   addr;
		logic              we;
		logic [XLEN-1:0]   wdata;
		logic [XLEN/8-1:0] wstrb;
	} mmu_req_t;

	typedef struct packed {
		logic [XLEN-1:0] rdata;
		logic [1:0]      resp;
	} mmu_rsp_t;

	// --------------------------------------------------------------------
	// page table entry
	// --------------------------------------------------------------------
	typedef struct packed {
		logic [11:0] ppn1;
		logic [9:0]  ppn0;
		logic [1:0]  rsw;
		logic        d;
		logic        a;
		logic        g;
		logic        u;
		logic        x;
		logic        w;
		logic        r;
		logic        v;
	} pte_t;

	// read data is an entry during a walk, plain data otherwise
	typedef union packed {
		pte_t            pte;
		logic [XLEN-1:0] data;
	} bus_word_u;

	typedef enum logic [1:0] {
		LEVEL1,
		LEVEL2,
		DATA
	} walk_phase_e;

	typedef enum logic [1:0] {
		POINTER,
		LEAF,
		FAULT
	} pte_verdict_e;

	// low part of the 22-bit ppn, enough for a 32-bit physical space
	function automatic logic [PPN_W-1:0] pte_ppn(pte_t pte);
		logic [21:0] full;
		full = {pte.ppn1, pte.ppn0};
		return full[PPN_W-1:0];
	endfunction

endpackage

// File: logic/walk_ctrl.sv
`timescale 1ns/1ps

module walk_ctrl (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  satp_mode,
	input  logic                  up_req_valid,
	input  logic                  up_rsp_ready,
	input  logic                  mem_req_ready,
	input  logic                  mem_rsp_valid,
	input  mmu_pkg::pte_verdict_e verdict,
	output logic                  bypass,
	output logic                  up_req_ready,
	output logic                  up_rsp_valid,
	output logic                  mem_req_valid,
	output logic                  mem_rsp_ready,
	output mmu_pkg::walk_phase_e  phase,
	output logic                  capture_req,
	output logic                  capture_pte,
	output logic                  fault
);
	import mmu_pkg::*;

	typedef enum logic [2:0] {
		S_IDLE,
		S_BYPASS,
		S_ISSUE,
		S_WAIT_RSP,
		S_RESPOND
	} state_e;

	state_e      state;
	state_e      state_next;
	walk_phase_e phase_next;
	logic        fault_next;
	logic        data_phase;

	// outstanding pass-through requests
	logic [2:0] byp_cnt;
	logic [2:0] byp_cnt_next;
	logic       byp_req_xfer;
	logic       byp_rsp_xfer;

	// --------------------------------------------------------------------
	// outputs
	// --------------------------------------------------------------------
	assign data_phase = (phase == DATA);

	// idle in bare mode already forwards, so bare mode costs no cycle
	assign bypass        = (state == S_BYPASS) || (state == S_IDLE && !satp_mode);
	assign up_req_ready  = (state == S_IDLE);
	assign mem_req_valid = (state == S_ISSUE);
	assign capture_req   = (state == S_IDLE) && satp_mode && up_req_valid;
	assign capture_pte   = (state == S_WAIT_RSP) && mem_rsp_valid && !data_phase;

	// data response goes straight up, the memory holds it until taken
	assign mem_rsp_ready = (state == S_WAIT_RSP) && (!data_phase || up_rsp_ready);
	assign up_rsp_valid  = (state == S_RESPOND) ||
		(state == S_WAIT_RSP && data_phase && mem_rsp_valid);

	assign byp_req_xfer = bypass && up_req_valid && mem_req_ready;
	assign byp_rsp_xfer = bypass && mem_rsp_valid && up_rsp_ready;
	assign byp_cnt_next = byp_cnt + {2'b00, byp_req_xfer} - {2'b00, byp_rsp_xfer};

	// --------------------------------------------------------------------
	// next state
	// --------------------------------------------------------------------
	always_comb begin
		state_next = state;
		phase_next = phase;
		fault_next = fault;
		case (state)
			S_IDLE: begin
				// satp mode only looked at here
				if (!satp_mode) begin
					if (byp_cnt_next != 3'd0) begin
						state_next = S_BYPASS;
					end
				end else if (up_req_valid) begin
					phase_next = LEVEL1;
					state_next = S_ISSUE;
				end
			end
			S_BYPASS: begin
				if (byp_cnt_next == 3'd0) begin
					state_next = S_IDLE;
				end
			end
			S_ISSUE: begin
				if (mem_req_ready) begin
					state_next = S_WAIT_RSP;
				end
			end
			S_WAIT_RSP: begin
				if (mem_rsp_valid) begin
					if (data_phase) begin
						if (up_rsp_ready) begin
							state_next = S_IDLE;
						end
					end else if (verdict == FAULT) begin
						fault_next = 1'b1;
						state_next = S_RESPOND;
					end else begin
						phase_next = (phase == LEVEL1) ? LEVEL2 : DATA;
						state_next = S_ISSUE;
					end
				end
			end
			S_RESPOND: begin
				if (up_rsp_ready) begin
					fault_next = 1'b0;
					state_next = S_IDLE;
				end
			end
			default: begin
				state_next = S_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state   <= S_IDLE;
			phase   <= LEVEL1;
			fault   <= 1'b0;
			byp_cnt <= 3'd0;
		end else begin
			state   <= state_next;
			phase   <= phase_next;
			fault   <= fault_next;
			byp_cnt <= byp_cnt_next;
		end
	end

	// --------------------------------------------------------------------
	// checks
	// --------------------------------------------------------------------
	// walk request and its phase stay put until the memory takes them
	a_req_held: assert property (@(posedge clk) disable iff (rst)
		mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(phase));

	// pass-through responses never come from the walker
	a_no_rsp_in_bypass: assert property (@(posedge clk) disable iff (rst)
		bypass |-> !up_rsp_valid && !fault);

endmodule

// File: logic/walk_addr_gen.sv
`timescale 1ns/1ps

module walk_addr_gen (
	input  logic                      clk,
	input  logic                      rst,
	input  logic [mmu_pkg::PPN_W-1:0] satp_ppn,
	input  mmu_pkg::walk_phase_e      phase,
	input  logic                      capture_req,
	input  logic                      capture_pte,
	input  mmu_pkg::mmu_req_t         up_req,
	input  mmu_pkg::bus_word_u        mem_rsp_data,
	output mmu_pkg::mmu_req_t         walk_req,
	output logic                      is_write
);
	import mmu_pkg::*;

	logic [XLEN-1:0]   vaddr_q;
	logic [XLEN-1:0]   wdata_q;
	logic [XLEN/8-1:0] wstrb_q;
	logic              we_q;
	pte_t              pte1_q;
	pte_t              pte2_q;

	logic [VPN_W-1:0]         vpn1;
	logic [VPN_W-1:0]         vpn0;
	logic [PAGE_OFFSET_W-1:0] offset;
	logic [XLEN-1:0]          l1_addr;
	logic [XLEN-1:0]          l2_addr;
	logic [XLEN-1:0]          phys_addr;

	always_ff @(posedge clk) begin
		if (rst) begin
			we_q <= 1'b0;
		end else if (capture_req) begin
			we_q <= up_req.we;
		end
	end

	always_ff @(posedge clk) begin
		if (capture_req) begin
			vaddr_q <= up_req.addr;
			wdata_q <= up_req.wdata;
			wstrb_q <= up_req.wstrb;
		end
	end

	// entry register picked by the level being fetched
	always_ff @(posedge clk) begin
		if (capture_pte) begin
			if (phase == LEVEL1) begin
				pte1_q <= mem_rsp_data.pte;
			end else begin
				pte2_q <= mem_rsp_data.pte;
			end
		end
	end

	assign vpn1   = vaddr_q[XLEN-1 -: VPN_W];
	assign vpn0   = vaddr_q[PAGE_OFFSET_W +: VPN_W];
	assign offset = vaddr_q[PAGE_OFFSET_W-1:0];

	// entries are 4 bytes, hence the two zero bits
	assign l1_addr   = {satp_ppn, vpn1, 2'b00};
	assign l2_addr   = {pte_ppn(pte1_q), vpn0, 2'b00};
	assign phys_addr = {pte_ppn(pte2_q), offset};

	always_comb begin
		walk_req.wdata = wdata_q;
		walk_req.wstrb = wstrb_q;
		walk_req.we    = 1'b0;
		case (phase)
			LEVEL1: begin
				walk_req.addr = l1_addr;
			end
			LEVEL2: begin
				walk_req.addr = l2_addr;
			end
			default: begin
				walk_req.addr = phys_addr;
				walk_req.we   = we_q;
			end
		endcase
	end

	assign is_write = we_q;

endmodule

// File: logic/pte_check.sv
`timescale 1ns/1ps

module pte_check (
	input  mmu_pkg::walk_phase_e  phase,
	input  logic                  is_write,
	input  mmu_pkg::bus_word_u    entry,
	output mmu_pkg::pte_verdict_e verdict
);
	import mmu_pkg::*;

	pte_t pte;
	logic malformed;
	logic is_leaf;
	logic no_perm;

	assign pte = entry.pte;

	// R, W and X all clear means a pointer to the next table
	assign is_leaf   = pte.r | pte.x;
	assign malformed = ~pte.v | (pte.w & ~pte.r);

	// U, G, A and D are not looked at
	assign no_perm = is_write ? ~pte.w : ~pte.r;

	always_comb begin
		verdict = FAULT;
		case (phase)
			LEVEL1: begin
				// a leaf here would be a superpage
				if (!malformed && !is_leaf) begin
					verdict = POINTER;
				end
			end
			LEVEL2: begin
				if (!malformed && is_leaf && !no_perm) begin
					verdict = LEAF;
				end
			end
			default: begin
				// data word, nothing to judge
				verdict = LEAF;
			end
		endcase
	end

endmodule

// File: logic/mem_port_mux.sv
`timescale 1ns/1ps

module mem_port_mux (
	input  logic              clk,
	input  logic              rst,
	input  logic              bypass,
	input  logic              fault,
	input  mmu_pkg::mmu_req_t up_req,
	input  logic              up_req_valid,
	input  logic              up_rsp_ready,
	input  mmu_pkg::mmu_req_t walk_req,
	input  logic              ctrl_up_req_ready,
	input  logic              ctrl_up_rsp_valid,
	input  logic              ctrl_mem_req_valid,
	input  logic              ctrl_mem_rsp_ready,
	input  logic              mem_req_ready,
	input  mmu_pkg::mmu_rsp_t mem_rsp,
	input  logic              mem_rsp_valid,
	output mmu_pkg::mmu_req_t mem_req,
	output logic              mem_req_valid,
	output logic              mem_rsp_ready,
	output mmu_pkg::mmu_rsp_t up_rsp,
	output logic              up_rsp_valid,
	output logic              up_req_ready
);
	import mmu_pkg::*;

	// --------------------------------------------------------------------
	// request side
	// --------------------------------------------------------------------
	assign mem_req       = bypass ? up_req : walk_req;
	assign mem_req_valid = bypass ? up_req_valid : ctrl_mem_req_valid;
	assign up_req_ready  = bypass ? mem_req_ready : ctrl_up_req_ready;

	// --------------------------------------------------------------------
	// response side
	// --------------------------------------------------------------------
	assign mem_rsp_ready = bypass ? up_rsp_ready : ctrl_mem_rsp_ready;
	assign up_rsp_valid  = bypass ? mem_rsp_valid : ctrl_up_rsp_valid;

	// faults return zero data
	always_comb begin
		up_rsp = mem_rsp;
		if (fault) begin
			up_rsp.rdata = '0;
			up_rsp.resp  = RESP_PAGE_FAULT;
		end
	end

	// client and walker never share the downstream port
	a_walker_quiet: assert property (@(posedge clk) disable iff (rst)
		bypass |-> !ctrl_mem_req_valid);

endmodule

// File: logic/sv32_mmu.sv
`timescale 1ns/1ps

module sv32_mmu (
	input  logic                     clk,
	input  logic                     rst,
	input  logic [mmu_pkg::XLEN-1:0] satp,
	input  mmu_pkg::mmu_req_t        up_req,
	input  logic                     up_req_valid,
	output logic                     up_req_ready,
	output mmu_pkg::mmu_rsp_t        up_rsp,
	output logic                     up_rsp_valid,
	input  logic                     up_rsp_ready,
	output mmu_pkg::mmu_req_t        mem_req,
	output logic                     mem_req_valid,
	input  logic                     mem_req_ready,
	input  mmu_pkg::mmu_rsp_t        mem_rsp,
	input  logic                     mem_rsp_valid,
	output logic                     mem_rsp_ready
);
	import mmu_pkg::*;

	logic             satp_mode;
	logic [PPN_W-1:0] satp_ppn;
	bus_word_u        rsp_word;

	logic         bypass;
	logic         fault;
	walk_phase_e  phase;
	pte_verdict_e verdict;
	logic         capture_req;
	logic         capture_pte;
	logic         is_write;
	mmu_req_t     walk_req;

	logic ctrl_up_req_ready;
	logic ctrl_up_rsp_valid;
	logic ctrl_mem_req_valid;
	logic ctrl_mem_rsp_ready;

	// mode in the top bit, root table ppn in the low bits
	assign satp_mode = satp[XLEN-1];
	assign satp_ppn  = satp[PPN_W-1:0];
	assign rsp_word  = mem_rsp.rdata;

	walk_ctrl u_walk_ctrl (
		.clk           (clk),
		.rst           (rst),
		.satp_mode     (satp_mode),
		.up_req_valid  (up_req_valid),
		.up_rsp_ready  (up_rsp_ready),
		.mem_req_ready (mem_req_ready),
		.mem_rsp_valid (mem_rsp_valid),
		.verdict       (verdict),
		.bypass        (bypass),
		.up_req_ready  (ctrl_up_req_ready),
		.up_rsp_valid  (ctrl_up_rsp_valid),
		.mem_req_valid (ctrl_mem_req_valid),
		.mem_rsp_ready (ctrl_mem_rsp_ready),
		.phase         (phase),
		.capture_req   (capture_req),
		.capture_pte   (capture_pte),
		.fault         (fault)
	);

	walk_addr_gen u_walk_addr_gen (
		.clk          (clk),
		.rst          (rst),
		.satp_ppn     (satp_ppn),
		.phase        (phase),
		.capture_req  (capture_req),
		.capture_pte  (capture_pte),
		.up_req       (up_req),
		.mem_rsp_data (rsp_word),
		.walk_req     (walk_req),
		.is_write     (is_write)
	);

	pte_check u_pte_check (
		.phase    (phase),
		.is_write (is_write),
		.entry    (rsp_word),
		.verdict  (verdict)
	);

	mem_port_mux u_mem_port_mux (
		.clk                (clk),
		.rst                (rst),
		.bypass             (bypass),
		.fault              (fault),
		.up_req             (up_req),
		.up_req_valid       (up_req_valid),
		.up_rsp_ready       (up_rsp_ready),
		.walk_req           (walk_req),
		.ctrl_up_req_ready  (ctrl_up_req_ready),
		.ctrl_up_rsp_valid  (ctrl_up_rsp_valid),
		.ctrl_mem_req_valid (ctrl_mem_req_valid),
		.ctrl_mem_rsp_ready (ctrl_mem_rsp_ready),
		.mem_req_ready      (mem_req_ready),
		.mem_rsp            (mem_rsp),
		.mem_rsp_valid      (mem_rsp_valid),
		.mem_req            (mem_req),
		.mem_req_valid      (mem_req_valid),
		.mem_rsp_ready      (mem_rsp_ready),
		.up_rsp             (up_rsp),
		.up_rsp_valid       (up_rsp_valid),
		.up_req_ready       (up_req_ready)
	);

endmodule

// File: dv/mem_model.sv
`timescale 1ns/1ps

module mem_model (
	input  logic              clk,
	input  logic              rst,
	input  mmu_pkg::mmu_req_t req,
	input  logic              req_valid,
	output logic              req_ready,
	output mmu_pkg::mmu_rsp_t rsp,
	output logic              rsp_valid,
	input  logic              rsp_ready
);
	import mmu_pkg::*;

	// sparse word store, keyed by word-aligned byte address
	logic [31:0] words [logic [31:0]];
	int          wr_count = 0;
	logic [31:0] lfsr_q = 32'hb53d;

	logic [2:0] req_wait;
	logic [2:0] rsp_wait;
	logic       pending;

	// Fibonacci LFSR, taps 32 22 2 1, stepped once per bit
	function automatic logic [2:0] rand_delay(input int n);
		logic [2:0] val;
		logic       fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[1:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old,
		input logic [31:0] wdata, input logic [3:0] wstrb);
		logic [31:0] word;
		word = old;
		for (int b = 0; b < 4; b++) begin
			if (wstrb[b]) begin
				word[8*b +: 8] = wdata[8*b +: 8];
			end
		end
		return word;
	endfunction

	always @(posedge clk) begin
		logic [31:0] key;
		logic [31:0] old;
		if (rst) begin
			req_ready <= 1'b0;
			rsp_valid <= 1'b0;
			pending   <= 1'b0;
			req_wait  <= '0;
			rsp_wait  <= '0;
			rsp       <= '0;
		end else begin
			if (req_valid && req_ready) begin
				key = {req.addr[31:2], 2'b00};
				// unwritten words read as zero, an invalid entry
				old = words.exists(key) ? words[key] : '0;
				req_ready <= 1'b0;
				pending   <= 1'b1;
				rsp_wait  <= rand_delay(3);
				rsp.resp  <= RESP_OKAY;
				if (req.we) begin
					words[key] = merge_bytes(old, req.wdata, req.wstrb);
					wr_count   = wr_count + 1;
					rsp.rdata <= '0;
				end else begin
					rsp.rdata <= old;
				end
			end else if (req_valid && !pending && !rsp_valid) begin
				if (req_wait == 3'd0) begin
					req_ready <= 1'b1;
				end else begin
					req_wait <= req_wait - 3'd1;
				end
			end
			if (pending) begin
				if (rsp_wait == 3'd0) begin
					rsp_valid <= 1'b1;
					pending   <= 1'b0;
				end else begin
					rsp_wait <= rsp_wait - 3'd1;
				end
			end
			// response held until taken, then a fresh request delay
			if (rsp_valid && rsp_ready) begin
				rsp_valid <= 1'b0;
				req_wait  <= rand_delay(2);
			end
		end
	end

endmodule

// File: dv/mmu_tb.sv
`timescale 1ns/1ps

module mmu_tb;
	import mmu_pkg::*;

	localparam int N_RAND   = 6;
	localparam int NUM_REQS = 10 + N_RAND;

	logic        clk;
	logic        rst;
	logic [31:0] satp;
	mmu_req_t    up_req;
	logic        up_req_valid;
	logic        up_req_ready;
	mmu_rsp_t    up_rsp;
	logic        up_rsp_valid;
	logic        up_rsp_ready;
	mmu_req_t    mem_req;
	logic        mem_req_valid;
	logic        mem_req_ready;
	mmu_rsp_t    mem_rsp;
	logic        mem_rsp_valid;
	logic        mem_rsp_ready;

	logic [31:0] lfsr_q = 32'hb53d;
	string       name_q[$];
	mmu_rsp_t    exp_q[$];
	int          rsp_count = 0;
	logic        stalled = 1'b0;
	mmu_rsp_t    stall_rsp;

	sv32_mmu UUT (
		.clk           (clk),
		.rst           (rst),
		.satp          (satp),
		.up_req        (up_req),
		.up_req_valid  (up_req_valid),
		.up_req_ready  (up_req_ready),
		.up_rsp        (up_rsp),
		.up_rsp_valid  (up_rsp_valid),
		.up_rsp_ready  (up_rsp_ready),
		.mem_req       (mem_req),
		.mem_req_valid (mem_req_valid),
		.mem_req_ready (mem_req_ready),
		.mem_rsp       (mem_rsp),
		.mem_rsp_valid (mem_rsp_valid),
		.mem_rsp_ready (mem_rsp_ready)
	);

	mem_model u_mem (
		.clk       (clk),
		.rst       (rst),
		.req       (mem_req),
		.req_valid (mem_req_valid),
		.req_ready (mem_req_ready),
		.rsp       (mem_rsp),
		.rsp_valid (mem_rsp_valid),
		.rsp_ready (mem_rsp_ready)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ----------------------------------------------------------------------
	// helpers
	// ----------------------------------------------------------------------
	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit
	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] val;
		logic       fb;
		val = '0;
		for (int i = 0; i < n; i++) begin
			fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
			lfsr_q = {lfsr_q[30:0], fb};
			val    = {val[6:0], fb};
		end
		return val;
	endfunction

	function automatic logic [31:0] peek(input logic [31:0] addr);
		if (u_mem.words.exists(addr)) begin
			return u_mem.words[addr];
		end
		return '0;
	endfunction

	function automatic void poke(input logic [31:0] addr, input logic [31:0] value);
		u_mem.words[addr] = value;
	endfunction

	function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
		return {ppn, 2'b00, flags};
	endfunction

	function automatic logic [31:0] data_pattern(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'ha5c3_5a3c;
	endfunction

	// reference Sv32 walk over the memory array
	function automatic void translate(input logic [31:0] va, input logic we,
		input logic [19:0] root, output logic [31:0] pa, output logic pf);
		pte_t l1;
		pte_t l2;
		pa = '0;
		pf = 1'b1;
		l1 = peek({root, va[31:22], 2'b00});
		// level 1 has to be a valid pointer
		if (l1.v && !l1.r && !l1.w && !l1.x) begin
			l2 = peek({l1.ppn1[9:0], l1.ppn0, va[21:12], 2'b00});
			if (l2.v && (l2.r || l2.x) && !(l2.w && !l2.r) && (we ? l2.w : l2.r)) begin
				pf = 1'b0;
				pa = {l2.ppn1[9:0], l2.ppn0, va[11:0]};
			end
		end
	endfunction

	task automatic check(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual) begin
			$display("error %s: expected %h actual %h", name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	task automatic load_tables();
		logic [31:0] addr;
		// root table at ppn 0x10 and level-2 table at ppn 0x11
		poke(32'h0001_0004, make_pte(22'h11, 8'h01));
		// superpage leaf at vpn1 3
		poke(32'h0001_000c, make_pte(22'h30, 8'h07));
		poke(32'h0001_1000, make_pte(22'h20, 8'h07));
		poke(32'h0001_1004, make_pte(22'h21, 8'h03));
		poke(32'h0001_100c, make_pte(22'h22, 8'h0f));
		for (int p = 32'h20; p <= 32'h22; p++) begin
			for (int w = 0; w < 16; w++) begin
				addr = (p << 12) + (w << 2);
				poke(addr, data_pattern(addr));
			end
		end
	endtask

	task automatic set_mode(input logic [31:0] value);
		@(posedge clk);
		satp <= value;
		@(negedge clk);
	endtask

	// one request with its expected response queued for the compare process
	task automatic do_access(input string name, input logic [31:0] va, input logic we,
		input logic [31:0] wdata);
		logic [31:0] pa;
		logic        pf;
		mmu_rsp_t    exp;
		int          wr_before;
		int          hold;
		pa = va;
		pf = 1'b0;
		if (satp[31]) begin
			translate(va, we, satp[19:0], pa, pf);
		end
		exp.resp  = pf ? RESP_PAGE_FAULT : RESP_OKAY;
		exp.rdata = (pf || we) ? 32'h0 : peek(pa);
		wr_before = u_mem.wr_count;
		name_q.push_back(name);
		exp_q.push_back(exp);
		@(posedge clk);
		up_req       <= '{addr: va, we: we, wdata: wdata, wstrb: 4'hf};
		up_req_valid <= 1'b1;
		do @(negedge clk); while (!up_req_ready);
		@(posedge clk);
		up_req_valid <= 1'b0;
		@(negedge clk);
		while (!up_rsp_valid) begin
			check({name, " one request in flight"}, 1'b0, up_req_ready);
			@(negedge clk);
		end
		// back-pressure for a random number of cycles
		hold = rand_bits(2);
		repeat (hold) begin
			check({name, " one request in flight"}, 1'b0, up_req_ready);
			@(negedge clk);
		end
		@(posedge clk);
		up_rsp_ready <= 1'b1;
		@(posedge clk);
		up_rsp_ready <= 1'b0;
		if (pf) begin
			check({name, " memory untouched"}, wr_before, u_mem.wr_count);
		end else if (we) begin
			check({name, " write landed"}, wdata, peek(pa));
		end
	endtask

	// ----------------------------------------------------------------------
	// response checker
	// ----------------------------------------------------------------------
	always @(negedge clk) begin
		if (rst) begin
			stalled = 1'b0;
		end else if (up_rsp_valid && exp_q.size() == 0) begin
			$display("error: response arrived with no request outstanding");
			$display("SOME TESTS FAILED");
			$fatal(1, "unexpected response");
		end else if (up_rsp_valid) begin
			if (stalled) begin
				check({name_q[0], " response held"}, stall_rsp, up_rsp);
			end
			if (up_rsp_ready) begin
				check(name_q[0], exp_q[0], up_rsp);
				void'(name_q.pop_front());
				void'(exp_q.pop_front());
				rsp_count = rsp_count + 1;
				stalled   = 1'b0;
			end else begin
				stalled   = 1'b1;
				stall_rsp = up_rsp;
			end
		end else if (stalled) begin
			$display("error: %s response dropped before it was taken", name_q[0]);
			$display("SOME TESTS FAILED");
			$fatal(1, "response withdrawn");
		end
	end

	initial begin
		repeat (NUM_REQS * 200 + 50) @(posedge clk);
		$display("error: run did not finish in %0d cycles", NUM_REQS * 200 + 50);
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog expired");
	end

	// ----------------------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------------------
	initial begin
		logic [7:0]  sel;
		logic [7:0]  word;
		logic [31:0] va;
		rst          <= 1'b1;
		satp         <= '0;
		up_req       <= '0;
		up_req_valid <= 1'b0;
		up_rsp_ready <= 1'b0;
		load_tables();
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		check("reset state", 3'b000, {up_rsp_valid, mem_req_valid, mem_rsp_ready});

		// bare mode
		do_access("bare write", 32'h0000_3000, 1'b1, 32'h1234_5678);
		do_access("bare read", 32'h0000_3000, 1'b0, 32'h0);
		do_access("bare preload read", 32'h0002_0004, 1'b0, 32'h0);

		// translated mode with the root table at ppn 0x10
		set_mode(32'h8000_0010);
		check("idle ready", 1'b1, up_req_ready);
		for (int i = 0; i < N_RAND; i++) begin
			sel  = rand_bits(1);
			word = rand_bits(4);
			va   = {10'd1, sel[0] ? 10'd1 : 10'd0, 6'd0, word[3:0], 2'b00};
			do_access("translated read", va, 1'b0, 32'h0);
		end
		do_access("translated write", 32'h0040_3010, 1'b1, 32'hdead_beef);
		do_access("translated read back", 32'h0040_3010, 1'b0, 32'h0);

		// faults
		do_access("level-1 invalid", 32'h0080_0040, 1'b0, 32'h0);
		do_access("level-2 invalid", 32'h0040_2004, 1'b1, 32'h0bad_0001);
		do_access("write to read-only", 32'h0040_1008, 1'b1, 32'h0bad_0002);
		do_access("level-1 leaf", 32'h00c0_0000, 1'b0, 32'h0);

		set_mode(32'h0000_0000);
		do_access("bare read of translated write", 32'h0002_2010, 1'b0, 32'h0);

		repeat (4) @(posedge clk);
		if (rsp_count == NUM_REQS && exp_q.size() == 0) begin
			$display("ALL TESTS PASSED");
			$finish;
		end else begin
			$display("error: %0d of %0d responses seen", rsp_count, NUM_REQS);
			$display("SOME TESTS FAILED");
			$fatal(1, "run incomplete");
		end
	end

endmodule

// File: all.f
logic/mmu_pkg.sv
logic/walk_ctrl.sv
logic/walk_addr_gen.sv
logic/pte_check.sv
logic/mem_port_mux.sv
logic/sv32_mmu.sv
dv/mem_model.sv
dv/mmu_tb.sv

// File: Bender.yml
package:
  name: sv32_mmu

sources:
  - files:
      - logic/mmu_pkg.sv
      - logic/walk_ctrl.sv
      - logic/walk_addr_gen.sv
      - logic/pte_check.sv
      - logic/mem_port_mux.sv
      - logic/sv32_mmu.sv
  - target: test
    files:
      - dv/mem_model.sv
      - dv/mmu_tb.sv
